//--- common/versat_pkg.sv
`default_nettype none

package versat_pkg;

   localparam int DATA_W     = 32;
   localparam int SAMPLE_W   = 16;
   localparam int DELAY_W    = 7;
   localparam int LEN_W      = 16;
   localparam int N_LANES    = 16;
   localparam int CNT_W      = 4;
   localparam int CFG_ADDR_W = 5;

   // addresses 0 to 15 select the lane coefficients
   localparam logic [CFG_ADDR_W-1:0] ADDR_DELAY = 5'd16;
   localparam logic [CFG_ADDR_W-1:0] ADDR_LEN   = 5'd17;

   typedef struct packed {
      logic                  en;
      logic [CFG_ADDR_W-1:0] addr;
      logic [DATA_W-1:0]     data;
   } cfg_write_t;

   typedef struct packed {
      logic [DATA_W-SAMPLE_W-1:0] pad;
      logic [SAMPLE_W-1:0]        coef;
   } cfg_coef_t;

   typedef struct packed {
      logic [DATA_W-LEN_W-DELAY_W-1:0] pad;
      logic [LEN_W-1:0]                len;    // bits 22 to 7
      logic [DELAY_W-1:0]              delay;  // bits 6 to 0
   } cfg_ctrl_t;

   // the same config word read as a coefficient or as control fields
   typedef union packed {
      cfg_coef_t coef;
      cfg_ctrl_t ctrl;
   } cfg_word_u;

   typedef logic [N_LANES-1:0][DATA_W-1:0]   lane_bus_t;
   typedef logic [N_LANES-1:0][SAMPLE_W-1:0] coef_bus_t;

   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic [CNT_W-1:0]  lane;
      logic              valid;
   } merge_out_t;

endpackage

`default_nettype wire

//--- hdl/config_regs.sv
`timescale 1ns/1ps
`default_nettype none

module config_regs (
   input  wire logic                           clk,
   input  wire logic                           rst,
   input  wire versat_pkg::cfg_write_t         cfg,
   output versat_pkg::coef_bus_t               coefs,
   output logic [versat_pkg::DELAY_W-1:0]      merge_delay,
   output logic [versat_pkg::LEN_W-1:0]        run_len
);

   import versat_pkg::*;

   cfg_word_u word;

   assign word = cfg.data;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         coefs       <= '0;
         merge_delay <= '0;
         run_len     <= '0;
      end else if (cfg.en) begin
         if (cfg.addr < N_LANES) begin
            coefs[cfg.addr[CNT_W-1:0]] <= word.coef.coef;
         end else if (cfg.addr == ADDR_DELAY) begin
            merge_delay <= word.ctrl.delay;
         end else if (cfg.addr == ADDR_LEN) begin
            run_len <= word.ctrl.len;
         end
         // anything above ADDR_LEN falls through and is dropped
      end
   end

endmodule

`default_nettype wire

//--- hdl/run_control.sv
`timescale 1ns/1ps
`default_nettype none

module run_control (
   input  wire logic                        clk,
   input  wire logic                        rst,
   input  wire logic                        start,
   input  wire logic [versat_pkg::LEN_W-1:0] run_len,
   output logic                             run,
   output logic                             running,
   output logic                             done
);

   import versat_pkg::*;

   logic [LEN_W-1:0] remain;
   logic             accept;

   assign accept = start && !running;  // starts inside a run are dropped

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         run     <= 1'b0;
         running <= 1'b0;
         done    <= 1'b0;
         remain  <= '0;
      end else begin
         run <= accept;

         // second term covers a zero length run that never raises running
         done <= (running && remain == LEN_W'(1)) || (run && !running);

         if (accept) begin
            running <= (run_len != '0);
            remain  <= run_len;
         end else if (running) begin
            remain <= remain - 1'b1;
            if (remain == LEN_W'(1)) begin
               running <= 1'b0;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- hdl/lane_scale.sv
`timescale 1ns/1ps
`default_nettype none

module lane_scale #(
   parameter int DEPTH = 0
) (
   input  wire logic                           clk,
   input  wire logic                           rst,
   input  wire logic                           run,
   input  wire logic                           running,
   input  wire logic [versat_pkg::SAMPLE_W-1:0] sample,
   input  wire logic [versat_pkg::SAMPLE_W-1:0] coef,
   output logic [versat_pkg::DATA_W-1:0]       product
);

   import versat_pkg::*;

   logic [DATA_W-1:0] mult;
   logic [DATA_W-1:0] pipe [0:DEPTH];

   assign mult = sample * coef;  // unsigned, full 32 bit result

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int j = 0; j <= DEPTH; j++) begin
            pipe[j] <= '0;
         end
      end else if (run) begin
         // the run cycle itself is a sampling cycle when running is up
         pipe[0] <= running ? mult : '0;
         for (int j = 1; j <= DEPTH; j++) begin
            pipe[j] <= '0;
         end
      end else if (running) begin
         pipe[0] <= mult;
         for (int j = 1; j <= DEPTH; j++) begin
            pipe[j] <= pipe[j-1];
         end
      end
   end

   assign product = pipe[DEPTH];

endmodule

`default_nettype wire

//--- merge/stream_merge.sv
`timescale 1ns/1ps
`default_nettype none

module stream_merge (
   input  wire logic                          clk,
   input  wire logic                          rst,
   input  wire logic                          run,
   input  wire logic                          running,
   input  wire logic [versat_pkg::DELAY_W-1:0] delay_cfg,
   input  wire versat_pkg::lane_bus_t          lanes,
   output versat_pkg::merge_out_t              out
);

   import versat_pkg::*;

   logic [DELAY_W-1:0] delay;
   logic [CNT_W-1:0]   counter;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         delay   <= '0;
         counter <= '0;
         out     <= '0;
      end else if (run) begin
         delay     <= delay_cfg;
         counter   <= '0;
         out.valid <= 1'b0;  // counter is stale on the run cycle
      end else if (running) begin
         if (delay != '0) begin
            delay <= delay - 1'b1;
         end else begin
            counter <= counter + 1'b1;  // wraps after lane 15
         end
         out.data  <= lanes[counter];
         out.lane  <= counter;
         out.valid <= 1'b1;
      end else begin
         out.valid <= 1'b0;
      end
   end

endmodule

`default_nettype wire

//--- hdl/versat_merge_top.sv
`timescale 1ns/1ps
`default_nettype none

module versat_merge_top (
   input  wire logic                           clk,
   input  wire logic                           rst,
   input  wire versat_pkg::cfg_write_t         cfg,
   input  wire logic                           start,
   input  wire logic [versat_pkg::SAMPLE_W-1:0] stream_in,
   output versat_pkg::merge_out_t              out,
   output logic                                running,
   output logic                                done
);

   import versat_pkg::*;

   coef_bus_t          coefs;
   lane_bus_t          lanes;
   logic [DELAY_W-1:0] merge_delay;
   logic [LEN_W-1:0]   run_len;
   logic               run;

   config_regs u_config_regs (
      .clk         (clk),
      .rst         (rst),
      .cfg         (cfg),
      .coefs       (coefs),
      .merge_delay (merge_delay),
      .run_len     (run_len)
   );

   run_control u_run_control (
      .clk     (clk),
      .rst     (rst),
      .start   (start),
      .run_len (run_len),
      .run     (run),
      .running (running),
      .done    (done)
   );

   // lane k is delayed k extra cycles to line up with the merge counter
   for (genvar k = 0; k < N_LANES; k++) begin : g_lane
      lane_scale #(
         .DEPTH (k)
      ) u_lane_scale (
         .clk     (clk),
         .rst     (rst),
         .run     (run),
         .running (running),
         .sample  (stream_in),
         .coef    (coefs[k]),
         .product (lanes[k])
      );
   end

   stream_merge u_stream_merge (
      .clk       (clk),
      .rst       (rst),
      .run       (run),
      .running   (running),
      .delay_cfg (merge_delay),
      .lanes     (lanes),
      .out       (out)
   );

endmodule

`default_nettype wire

//--- sim/versat_merge_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module versat_merge_asserts (
   input wire logic                             clk,
   input wire logic                             rst,
   input wire logic                             run,
   input wire logic                             running,
   input wire logic                             done,
   input wire logic                             valid,
   input wire logic [versat_pkg::CNT_W-1:0]     counter,
   input wire logic [versat_pkg::DELAY_W-1:0]   delay
);

   int fail_count = 0;

   run_single: assert property (@(posedge clk) disable iff (rst) run |=> !run)
      else begin
         fail_count = fail_count + 1;
         $error("run stayed high for more than one cycle");
      end

   // the output register lags running by one cycle
   valid_in_run: assert property (@(posedge clk) disable iff (rst) valid |-> $past(running))
      else begin
         fail_count = fail_count + 1;
         $error("out.valid high without running in the cycle before");
      end

   // a zero length run has no fall, so done follows the run pulse instead
   done_after_fall: assert property (@(posedge clk) disable iff (rst)
      done |-> !running && ($past(running) || $past(run)))
      else begin
         fail_count = fail_count + 1;
         $error("done pulsed without running falling or a zero length run");
      end

   counter_hold: assert property (@(posedge clk) disable iff (rst)
      (running && !run && delay != '0) |=> $stable(counter))
      else begin
         fail_count = fail_count + 1;
         $error("lane counter moved while the start delay was nonzero");
      end

endmodule

bind stream_merge versat_merge_asserts u_merge_asserts (
   .clk     (clk),
   .rst     (rst),
   .run     (run),
   .running (running),
   .done    (1'b0),
   .valid   (out.valid),
   .counter (counter),
   .delay   (delay)
);

bind run_control versat_merge_asserts u_ctrl_asserts (
   .clk     (clk),
   .rst     (rst),
   .run     (run),
   .running (running),
   .done    (done),
   .valid   (1'b0),
   .counter ('0),
   .delay   ('0)
);

`default_nettype wire

//--- sim/tb_versat_merge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_versat_merge;

   import versat_pkg::*;

   localparam int          N_RAND = 6;
   localparam int          N_RUNS = 5 + N_RAND;  // five directed runs, then the random ones
   localparam logic [31:0] SEED   = 32'd2;

   logic                clk;
   logic                rst;
   cfg_write_t          cfg;
   logic                start;
   logic [SAMPLE_W-1:0] stream_in;
   merge_out_t          out;
   logic                running;
   logic                done;

   logic [31:0]         rnd;
   int                  cycles = 0;
   int                  cycle_limit;
   logic [LEN_W-1:0]    rand_len [N_RAND];
   logic [DELAY_W-1:0]  rand_delay [N_RAND];

   // reference model state which updates once per clock cycle
   logic [SAMPLE_W-1:0] m_coef [N_LANES];
   logic [DELAY_W-1:0]  m_delay_cfg;
   logic [LEN_W-1:0]    m_len_cfg;
   logic [DELAY_W-1:0]  m_delay;
   logic [CNT_W-1:0]    m_counter;
   logic                m_run;
   logic                m_running;
   logic                m_done;
   int                  m_remain;
   logic [SAMPLE_W-1:0] hist [$];      // samples of the current run where index 0 is the run cycle
   merge_out_t          exp_out;

   versat_merge_top u_versat_merge_top (
      .clk       (clk),
      .rst       (rst),
      .cfg       (cfg),
      .start     (start),
      .stream_in (stream_in),
      .out       (out),
      .running   (running),
      .done      (done)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [31:0] lcg(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   // lane k at selected cycle cyc holds coef[k] times the sample of cycle cyc-1-k
   function automatic merge_out_t expected_merge(input int cyc, input logic [CNT_W-1:0] lane);
      merge_out_t r;
      int         src;
      r.valid = 1'b1;
      r.lane  = lane;
      src     = cyc - 1 - int'(lane);
      if (src < 0) begin
         r.data = '0;  // stage was cleared by the run pulse
      end else begin
         r.data = {16'h0, m_coef[lane]} * {16'h0, hist[src]};
      end
      return r;
   endfunction

   task automatic stop_on_error();
      $display("TEST RESULT: FAIL");
      $fatal(1, "stopping at the first failure");
   endtask

   task automatic check_out(input merge_out_t got, input merge_out_t exp);
      if (got !== exp) begin
         $write("error out at %0t: got data %08h lane %0h valid %0h",
                $time, got.data, got.lane, got.valid);
         $display(", expected data %08h lane %0h valid %0h",
                  exp.data, exp.lane, exp.valid);
         stop_on_error();
      end
   endtask

   task automatic check_running(input logic got, input logic exp);
      if (got !== exp) begin
         $display("error running at %0t: got %0h, expected %0h", $time, got, exp);
         stop_on_error();
      end
   endtask

   task automatic check_done(input logic got, input logic exp);
      if (got !== exp) begin
         $display("error done at %0t: got %0h, expected %0h", $time, got, exp);
         stop_on_error();
      end
   endtask

   task automatic clear_model();
      for (int k = 0; k < N_LANES; k++) begin
         m_coef[k] = '0;
      end
      m_delay_cfg = '0;
      m_len_cfg   = '0;
      m_delay     = '0;
      m_counter   = '0;
      m_run       = 1'b0;
      m_running   = 1'b0;
      m_done      = 1'b0;
      m_remain    = 0;
      exp_out     = '0;
      hist.delete();
   endtask

   // advances the model by one clock using the inputs of the current cycle
   task automatic advance_model();
      logic       accept;
      logic       n_run;
      logic       n_running;
      logic       n_done;
      int         n_remain;
      merge_out_t n_out;
      accept    = start && !m_running;  // a start inside a run is ignored
      n_run     = accept;
      n_running = m_running;
      n_remain  = m_remain;
      if (accept) begin
         n_running = (m_len_cfg != '0);
         n_remain  = m_len_cfg;
      end else if (m_running) begin
         n_remain = m_remain - 1;
         if (m_remain == 1) begin
            n_running = 1'b0;
         end
      end
      // done comes right after running falls, or after the run pulse of a zero length run
      n_done = (m_running && !n_running) || (m_run && !m_running);

      n_out = exp_out;
      if (m_run) begin
         hist.delete();
         m_delay     = m_delay_cfg;
         m_counter   = '0;
         n_out.valid = 1'b0;
         if (m_running) begin
            hist.push_back(stream_in);
         end
      end else if (m_running) begin
         n_out = expected_merge(hist.size(), m_counter);
         if (m_delay != '0) begin
            m_delay = m_delay - 1'b1;
         end else begin
            m_counter = m_counter + 1'b1;
         end
         hist.push_back(stream_in);
      end else begin
         n_out.valid = 1'b0;
      end

      // coefficient in bits 15:0, delay in bits 6:0, length in bits 22:7
      if (cfg.en) begin
         if (cfg.addr < 5'd16) begin
            m_coef[cfg.addr[3:0]] = cfg.data[15:0];
         end else if (cfg.addr == 5'd16) begin
            m_delay_cfg = cfg.data[6:0];
         end else if (cfg.addr == 5'd17) begin
            m_len_cfg = cfg.data[22:7];
         end
      end

      m_run     = n_run;
      m_running = n_running;
      m_remain  = n_remain;
      m_done    = n_done;
      exp_out   = n_out;
   endtask

   always @(negedge clk) begin
      if (!rst) begin
         check_out(out, exp_out);
         check_running(running, m_running);
         check_done(done, m_done);
         if (u_versat_merge_top.u_stream_merge.u_merge_asserts.fail_count != 0 ||
             u_versat_merge_top.u_run_control.u_ctrl_asserts.fail_count != 0) begin
            $display("a bound assertion on the merge unit or run control failed");
            stop_on_error();
         end
         advance_model();
      end
   end

   always @(posedge clk) begin
      if (!rst) begin
         cycles = cycles + 1;
         if (cycles > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            stop_on_error();
         end
      end
   end

   // every cycle gets a fresh sample on stream_in
   task automatic next_cycle();
      @(posedge clk);
      rnd = lcg(rnd);
      stream_in <= rnd[31:16];
   endtask

   task automatic write_cfg(input logic [CFG_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
      next_cycle();
      cfg.en   <= 1'b1;
      cfg.addr <= addr;
      cfg.data <= data;
      next_cycle();
      cfg.en   <= 1'b0;
   endtask

   // unused bits of the control words carry random junk
   task automatic write_ctrl(input logic [DELAY_W-1:0] delay, input logic [LEN_W-1:0] len);
      logic [DATA_W-1:0] w;
      rnd     = lcg(rnd);
      w       = rnd;
      w[6:0]  = delay;
      write_cfg(ADDR_DELAY, w);
      rnd     = lcg(rnd);
      w       = rnd;
      w[22:7] = len;
      write_cfg(ADDR_LEN, w);
   endtask

   task automatic wait_done();
      next_cycle();
      @(negedge clk);
      while (!done) begin
         next_cycle();
         @(negedge clk);
      end
   endtask

   task automatic do_run(input logic [DELAY_W-1:0] delay, input logic [LEN_W-1:0] len,
                         input logic restart);
      write_ctrl(delay, len);
      next_cycle();
      start <= 1'b1;
      next_cycle();
      start <= 1'b0;
      if (restart) begin
         repeat (3) next_cycle();
         start <= 1'b1;  // lands inside the run
         next_cycle();
         start <= 1'b0;
      end
      wait_done();
   endtask

   initial begin
      int total;
      rst       = 1'b1;
      start     = 1'b0;
      cfg       = '0;
      stream_in = '0;
      rnd       = SEED;
      clear_model();

      total = 40 + 30 + 20 + 0 + 25;
      for (int i = 0; i < N_RAND; i++) begin
         rnd           = lcg(rnd);
         rand_len[i]   = 16'd1 + rnd[31:16] % 16'd48;
         rnd           = lcg(rnd);
         rand_delay[i] = 7'(rnd[31:16] % 16'd24);
         total         = total + int'(rand_len[i]);
      end
      cycle_limit = total + 50 * N_RUNS;

      repeat (10) @(posedge clk);
      rst <= 1'b0;

      repeat (20) next_cycle();  // idle cycles where nothing may move

      for (int k = 0; k < N_LANES; k++) begin
         rnd = lcg(rnd);
         write_cfg(CFG_ADDR_W'(k), rnd);
      end
      do_run(7'd0, 16'd40, 1'b0);
      do_run(7'd5, 16'd30, 1'b0);
      do_run(7'd2, 16'd20, 1'b1);
      do_run(7'd3, 16'd0, 1'b0);

      rnd = lcg(rnd);
      write_cfg(5'd3, rnd);
      rnd = lcg(rnd);
      write_cfg(5'd18, rnd);
      rnd = lcg(rnd);
      write_cfg(5'd31, rnd);
      do_run(7'd1, 16'd25, 1'b0);

      for (int i = 0; i < N_RAND; i++) begin
         do_run(rand_delay[i], rand_len[i], 1'b0);
      end

      repeat (5) next_cycle();
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- compile.f
common/versat_pkg.sv
hdl/config_regs.sv
hdl/run_control.sv
hdl/lane_scale.sv
merge/stream_merge.sv
hdl/versat_merge_top.sv
sim/versat_merge_asserts.sv
sim/tb_versat_merge.sv
